//--- sources.f
design/seq_pkg.sv
design/regs_pkg.sv
design/rail_sequencer.sv
design/fault_monitor.sv
design/status_regs.sv
design/power_seq_top.sv
sim/tb_power_seq.sv

//--- Makefile
# Verilator build and run for the power-rail sequencer testbench

TOP = tb_power_seq

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f sources.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_power_seq.sv
// Power-rail sequencer testbench
// Rail model with random power-good delays, four-phase host reads
// checked against a reference of the register map

`timescale 1ns/1ns

module tb_power_seq;

	import seq_pkg::*;
	import regs_pkg::*;

	localparam int NR = 4;

	logic          clk_in;
	logic          reset;
	logic          sys_en;
	logic [NR-1:0] pg;
	logic [NR-1:0] en;
	logic          sys_good;
	logic          reg_req;
	reg_addr_t     reg_addr;
	logic          reg_ack;
	reg_data_t     reg_data;

	// Rail model state
	logic [NR-1:0] prev_en;
	logic [NR-1:0] withhold;
	logic [NR-1:0] force_low;
	logic [NR-1:0] pg_at_drop;
	int            pg_cnt [NR];
	logic [15:0]   lfsr;
	logic          check_up;
	logic          check_down;

	// Expected DUT state kept by the tests
	logic          rec_wait_err;
	logic          rec_op_err;
	logic          rec_fault;
	logic          rec_sys_en;
	logic          rec_sys_good;
	logic [15:0]   rec_pg;

	reg_addr_t     addr_q [$];
	reg_data_t     got_q [$];
	reg_data_t     exp_q [$];
	reg_addr_t     cmp_addr;
	reg_data_t     cmp_got;
	reg_data_t     cmp_exp;

	int            errors;
	int            checks;
	int            tests;
	int            err_at_start;
	string         test_name;

	power_seq_top #(
		.NUM_RAILS       (NR),
		.DELAY_CYCLES    (8),
		.WATCHDOG_CYCLES (64)
	) dut_i (
		.clk_in   (clk_in),
		.reset    (reset),
		.sys_en   (sys_en),
		.pg       (pg),
		.en       (en),
		.sys_good (sys_good),
		.reg_req  (reg_req),
		.reg_addr (reg_addr),
		.reg_ack  (reg_ack),
		.reg_data (reg_data)
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// Expected read value from the register map rules
	function automatic reg_data_t expected_read(input reg_addr_t addr);
		case (addr)
			ADDR_VERSION: return FPGA_VERSION;
			ADDR_CLEAR:   return CLEAR_VALUE;
			ADDR_PG_HIGH: return rec_pg[15:8];
			ADDR_PG_LOW:  return rec_pg[7:0];
			ADDR_STATUS:  return {3'b000, rec_wait_err, rec_op_err, rec_fault,
				rec_sys_en, rec_sys_good};
			default:      return 8'h00;
		endcase
	endfunction

	// Rail model and enable order checks
	always @(negedge clk_in) begin
		for (int i = 0; i < NR; i++) begin
			if (check_up && i > 0 && en[i] && !prev_en[i]) begin
				assert (en[i-1] && pg[i-1]) else begin
					$display("Rail %0d enabled at %0t while rail %0d was not up",
						i, $time, i - 1);
					errors++;
				end
			end
			if (check_down && i < NR - 1 && !en[i] && prev_en[i]) begin
				assert (!en[i+1] && !pg[i+1]) else begin
					$display("Rail %0d disabled at %0t while rail %0d was still up",
						i, $time, i + 1);
					errors++;
				end
			end
		end
		// Last power-good vector seen while any rail was still enabled
		if (en != '0) begin
			pg_at_drop = pg;
		end
		for (int i = 0; i < NR; i++) begin
			if (!en[i]) begin
				pg[i] = 1'b0;
				pg_cnt[i] = 0;
			end else if (!prev_en[i]) begin
				pg_cnt[i] = 1 + rand_bits(5) % 20;
			end else if (pg_cnt[i] > 0) begin
				if (pg_cnt[i] == 1 && !withhold[i]) begin
					pg[i] = 1'b1;
				end
				pg_cnt[i] = pg_cnt[i] - 1;
			end
			if (force_low[i]) begin
				pg[i] = 1'b0;
			end
		end
		prev_en = en;
	end

	// Compare each finished read with its expected value
	always @(negedge clk_in) begin
		while (addr_q.size() > 0) begin
			cmp_addr = addr_q.pop_front();
			cmp_got = got_q.pop_front();
			cmp_exp = exp_q.pop_front();
			checks++;
			assert (cmp_got == cmp_exp) else begin
				$display("Fail %0t reg_data[addr %0d]: got %h expected %h",
					$time, cmp_addr, cmp_got, cmp_exp);
				errors++;
			end
		end
	end

	task automatic read_check(input reg_addr_t addr);
		int n;
		@(negedge clk_in);
		reg_addr = addr;
		reg_req = 1'b1;
		n = 0;
		while (!reg_ack && n < 20) begin
			@(negedge clk_in);
			n++;
		end
		if (!reg_ack) begin
			$display("Timeout at %0t waiting for reg_ack to rise", $time);
			errors++;
		end else begin
			addr_q.push_back(addr);
			got_q.push_back(reg_data);
			exp_q.push_back(expected_read(addr));
		end
		reg_req = 1'b0;
		n = 0;
		while (reg_ack && n < 20) begin
			@(negedge clk_in);
			n++;
		end
		if (reg_ack) begin
			$display("Timeout at %0t waiting for reg_ack to fall", $time);
			errors++;
		end
	endtask

	task automatic wait_sys_good(input logic level, input int limit);
		int n;
		n = 0;
		while (sys_good !== level && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		if (sys_good !== level) begin
			$display("Timeout at %0t waiting for sys_good to become %b", $time, level);
			errors++;
		end
	endtask

	task automatic wait_en(input logic [NR-1:0] mask, input logic [NR-1:0] value,
		input int limit);
		int n;
		n = 0;
		while ((en & mask) !== value && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		if ((en & mask) !== value) begin
			$display("Timeout at %0t waiting for enables %b under mask %b",
				$time, value, mask);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = errors;
		tests++;
	endtask

	task automatic end_test();
		repeat (2) @(negedge clk_in);
		if (errors == err_at_start) begin
			$display("Test %s: ok", test_name);
		end else begin
			$display("Test %s: %0d errors", test_name, errors - err_at_start);
		end
	endtask

	task automatic clear_record();
		rec_wait_err = 1'b0;
		rec_op_err = 1'b0;
		rec_fault = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		sys_en = 1'b0;
		reg_req = 1'b0;
		reg_addr = '0;
		pg = '0;
		prev_en = '0;
		withhold = '0;
		force_low = '0;
		pg_at_drop = '0;
		for (int i = 0; i < NR; i++) begin
			pg_cnt[i] = 0;
		end
		lfsr = 16'd32975;
		check_up = 1'b1;
		check_down = 1'b0;
		clear_record();
		rec_sys_en = 1'b0;
		rec_sys_good = 1'b0;
		rec_pg = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		repeat (3) @(posedge clk_in);
		@(negedge clk_in);
		reset = 1'b0;

		start_test("power_up");
		sys_en = 1'b1;
		wait_sys_good(1'b1, 400);
		wait_en('1, '1, 5);
		rec_sys_en = 1'b1;
		rec_sys_good = 1'b1;
		rec_pg = 16'(pg);
		read_check(ADDR_STATUS);
		read_check(ADDR_PG_LOW);
		read_check(ADDR_PG_HIGH);
		end_test();

		start_test("version");
		read_check(ADDR_VERSION);
		read_check(8'h42);
		end_test();

		start_test("op_fault");
		force_low = 4'b0010;
		wait_en('1, '0, 40);
		wait_sys_good(1'b0, 5);
		rec_op_err = 1'b1;
		rec_fault = 1'b1;
		rec_sys_good = 1'b0;
		rec_pg = 16'(pg_at_drop);
		read_check(ADDR_STATUS);
		read_check(ADDR_PG_LOW);
		end_test();

		start_test("clear");
		force_low = '0;
		read_check(ADDR_CLEAR);
		clear_record();
		wait_sys_good(1'b1, 400);
		rec_sys_good = 1'b1;
		rec_pg = 16'(pg);
		read_check(ADDR_STATUS);
		read_check(ADDR_PG_LOW);
		end_test();

		start_test("power_down");
		check_up = 1'b0;
		check_down = 1'b1;
		sys_en = 1'b0;
		// Two sync stages plus the done-flag clear
		wait_sys_good(1'b0, 5);
		wait_en('1, '0, 200);
		rec_sys_en = 1'b0;
		rec_sys_good = 1'b0;
		rec_pg = '0;
		read_check(ADDR_STATUS);
		read_check(ADDR_PG_LOW);
		end_test();

		start_test("watchdog");
		check_down = 1'b0;
		check_up = 1'b1;
		withhold = 4'b0100;
		sys_en = 1'b1;
		wait_en(4'b0100, 4'b0100, 200);
		wait_en('1, '0, 200);
		rec_wait_err = 1'b1;
		rec_fault = 1'b1;
		rec_sys_en = 1'b1;
		rec_pg = 16'(pg_at_drop);
		read_check(ADDR_STATUS);
		read_check(ADDR_PG_LOW);
		withhold = '0;
		read_check(ADDR_CLEAR);
		clear_record();
		wait_sys_good(1'b1, 400);
		rec_sys_good = 1'b1;
		rec_pg = 16'(pg);
		read_check(ADDR_STATUS);
		end_test();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- design/power_seq_top.sv
// Power-rail sequencer top level
// Chains the rail enables with settle delays, watches for faults
// and exposes status to a host through a small register port

`timescale 1ns/1ns

module power_seq_top #(
	parameter int NUM_RAILS       = seq_pkg::DEFAULT_NUM_RAILS,
	parameter int DELAY_CYCLES    = seq_pkg::DEFAULT_DELAY_CYCLES,
	parameter int WATCHDOG_CYCLES = seq_pkg::DEFAULT_WATCHDOG_CYCLES
) (
	input  logic                 clk_in,
	input  logic                 reset,
	input  logic                 sys_en,
	input  logic [NUM_RAILS-1:0] pg,
	output logic [NUM_RAILS-1:0] en,
	output logic                 sys_good,
	input  logic                 reg_req,
	input  regs_pkg::reg_addr_t  reg_addr,
	output logic                 reg_ack,
	output regs_pkg::reg_data_t  reg_data
);

	logic [NUM_RAILS-1:0] pg_sync;
	logic                 sys_en_sync;
	logic [NUM_RAILS-1:0] rail_done;
	logic                 delay_active;
	logic                 fault;
	logic                 wait_err;
	logic                 op_err;
	logic                 clear_err;
	logic [15:0]          pg_snapshot;

	rail_sequencer #(
		.NUM_RAILS    (NUM_RAILS),
		.DELAY_CYCLES (DELAY_CYCLES)
	) rail_sequencer_i (
		.clk_in       (clk_in),
		.reset        (reset),
		.sys_en       (sys_en),
		.pg           (pg),
		.fault        (fault),
		.en           (en),
		.pg_sync      (pg_sync),
		.sys_en_sync  (sys_en_sync),
		.rail_done    (rail_done),
		.delay_active (delay_active),
		.sys_good     (sys_good)
	);

	fault_monitor #(
		.NUM_RAILS       (NUM_RAILS),
		.WATCHDOG_CYCLES (WATCHDOG_CYCLES)
	) fault_monitor_i (
		.clk_in       (clk_in),
		.reset        (reset),
		.en           (en),
		.pg_sync      (pg_sync),
		.rail_done    (rail_done),
		.delay_active (delay_active),
		.clear_err    (clear_err),
		.wait_err     (wait_err),
		.op_err       (op_err),
		.fault        (fault),
		.pg_snapshot  (pg_snapshot)
	);

	status_regs #(
		.NUM_RAILS (NUM_RAILS)
	) status_regs_i (
		.clk_in      (clk_in),
		.reset       (reset),
		.reg_req     (reg_req),
		.reg_addr    (reg_addr),
		.reg_ack     (reg_ack),
		.reg_data    (reg_data),
		.clear_err   (clear_err),
		.wait_err    (wait_err),
		.op_err      (op_err),
		.fault       (fault),
		.sys_en_sync (sys_en_sync),
		.sys_good    (sys_good),
		.pg_snapshot (pg_snapshot)
	);

endmodule

//--- design/status_regs.sv
// Status register port
// Read-only register map behind a four-phase req/ack handshake;
// reading the clear address also pulses the error clear

`timescale 1ns/1ns

module status_regs #(
	parameter int NUM_RAILS = seq_pkg::DEFAULT_NUM_RAILS
) (
	input  logic                clk_in,
	input  logic                reset,
	input  logic                reg_req,
	input  regs_pkg::reg_addr_t reg_addr,
	output logic                reg_ack,
	output regs_pkg::reg_data_t reg_data,
	output logic                clear_err,
	input  logic                wait_err,
	input  logic                op_err,
	input  logic                fault,
	input  logic                sys_en_sync,
	input  logic                sys_good,
	input  logic [15:0]         pg_snapshot
);

	import regs_pkg::*;

	// Only existing rails show up in the power-good registers
	localparam logic [15:0] PG_MASK = 16'((17'd1 << NUM_RAILS) - 17'd1);

	reg_state_e  state;
	reg_data_t   read_value;
	logic [15:0] pg_masked;
	reg_data_t   status_byte;

	assign pg_masked   = pg_snapshot & PG_MASK;
	assign status_byte = {3'b000, wait_err, op_err, fault, sys_en_sync, sys_good};

	// Register map decode
	always_comb begin
		case (reg_addr)
			ADDR_VERSION: read_value = FPGA_VERSION;
			ADDR_CLEAR:   read_value = CLEAR_VALUE;
			ADDR_PG_HIGH: read_value = pg_masked[15:8];
			ADDR_PG_LOW:  read_value = pg_masked[7:0];
			ADDR_STATUS:  read_value = status_byte;
			default:      read_value = '0;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			state     <= REG_IDLE;
			clear_err <= 1'b0;
		end else begin
			clear_err <= 1'b0;
			case (state)
				REG_IDLE: begin
					if (reg_req) begin
						state     <= REG_ACK;
						clear_err <= (reg_addr == ADDR_CLEAR);
					end
				end
				REG_ACK: begin
					// Wait for the host to drop its request
					if (!reg_req) begin
						state <= REG_IDLE;
					end
				end
				default: state <= REG_IDLE;
			endcase
		end
	end

	// Read data is captured on accept and held through the ack phase
	always_ff @(posedge clk_in) begin
		if (state == REG_IDLE && reg_req) begin
			reg_data <= read_value;
		end
	end

	assign reg_ack = (state == REG_ACK);

	a_ack_after_req : assert property (@(posedge clk_in) disable iff (reset)
		$rose(reg_ack) |-> $past(reg_req));

endmodule

//--- design/fault_monitor.sv
// Fault monitor
// Watchdog between each rail enable and its power-good, loss-of-good
// check on settled rails, latched fault and the frozen power-good snapshot

`timescale 1ns/1ns

module fault_monitor #(
	parameter int NUM_RAILS       = seq_pkg::DEFAULT_NUM_RAILS,
	parameter int WATCHDOG_CYCLES = seq_pkg::DEFAULT_WATCHDOG_CYCLES
) (
	input  logic                 clk_in,
	input  logic                 reset,
	input  logic [NUM_RAILS-1:0] en,
	input  logic [NUM_RAILS-1:0] pg_sync,
	input  logic [NUM_RAILS-1:0] rail_done,
	input  logic                 delay_active,
	input  logic                 clear_err,
	output logic                 wait_err,
	output logic                 op_err,
	output logic                 fault,
	output logic [15:0]          pg_snapshot
);

	import seq_pkg::*;

	localparam logic [COUNT_WIDTH-1:0] WD_LIMIT = COUNT_WIDTH'(WATCHDOG_CYCLES);

	logic [COUNT_WIDTH-1:0] w_count;
	logic [NUM_RAILS-1:0]   snap;
	logic                   rail_waiting;
	logic                   rail_lost;

	// Some rail enabled but not yet reporting good
	assign rail_waiting = |(en & ~pg_sync);

	// A settled rail has lost its power-good
	assign rail_lost = |(rail_done & ~pg_sync);

	// Watchdog restarts while a settle delay runs or no rail waits
	always_ff @(posedge clk_in) begin
		if (reset) begin
			w_count  <= '0;
			wait_err <= 1'b0;
		end else if (clear_err) begin
			w_count  <= '0;
			wait_err <= 1'b0;
		end else if (delay_active || !rail_waiting) begin
			w_count <= '0;
		end else if (w_count == WD_LIMIT) begin
			w_count  <= '0;
			wait_err <= 1'b1;
		end else begin
			w_count <= w_count + 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			op_err <= 1'b0;
		end else if (clear_err) begin
			op_err <= 1'b0;
		end else if (rail_lost) begin
			op_err <= 1'b1;
		end
	end

	// Fault follows the error flags by one cycle and holds until cleared
	always_ff @(posedge clk_in) begin
		if (reset) begin
			fault <= 1'b0;
		end else if (clear_err) begin
			fault <= 1'b0;
		end else if (wait_err || op_err) begin
			fault <= 1'b1;
		end
	end

	// Snapshot freezes on fault so the host sees the pre-fault state
	always_ff @(posedge clk_in) begin
		if (reset) begin
			snap <= '0;
		end else if (!fault) begin
			snap <= pg_sync;
		end
	end

	assign pg_snapshot = 16'(snap);

	a_fault_hold : assert property (@(posedge clk_in) disable iff (reset)
		$fell(fault) |-> $past(clear_err));

endmodule

//--- design/rail_sequencer.sv
// Rail sequencer
// Synchronizes power-good and system enable, drives the enable chain
// and times the settle delay of each rail before the next one starts

`timescale 1ns/1ns

module rail_sequencer #(
	parameter int NUM_RAILS    = seq_pkg::DEFAULT_NUM_RAILS,
	parameter int DELAY_CYCLES = seq_pkg::DEFAULT_DELAY_CYCLES
) (
	input  logic                 clk_in,
	input  logic                 reset,
	input  logic                 sys_en,
	input  logic [NUM_RAILS-1:0] pg,
	input  logic                 fault,
	output logic [NUM_RAILS-1:0] en,
	output logic [NUM_RAILS-1:0] pg_sync,
	output logic                 sys_en_sync,
	output logic [NUM_RAILS-1:0] rail_done,
	output logic                 delay_active,
	output logic                 sys_good
);

	import seq_pkg::*;

	localparam logic [COUNT_WIDTH-1:0] DELAY_LIMIT = COUNT_WIDTH'(DELAY_CYCLES);

	logic [NUM_RAILS-1:0] pg_s1;
	logic                 sys_en_s1;
	logic [COUNT_WIDTH-1:0] d_count;
	wire  [NUM_RAILS-1:0] en_chain;
	logic [NUM_RAILS-1:0] settle_cand;
	logic [NUM_RAILS-1:0] settle_sel;

	// Two-stage synchronizers
	always_ff @(posedge clk_in) begin
		if (reset) begin
			pg_s1       <= '0;
			pg_sync     <= '0;
			sys_en_s1   <= 1'b0;
			sys_en_sync <= 1'b0;
		end else begin
			pg_s1       <= pg;
			pg_sync     <= pg_s1;
			sys_en_s1   <= sys_en;
			sys_en_sync <= sys_en_s1;
		end
	end

	// A rail comes up once the previous one is done
	// and stays on until the next rail loses good
	genvar i;
	generate
		for (i = 0; i < NUM_RAILS; i++) begin : g_chain
			if (NUM_RAILS == 1) begin : g_only
				assign en_chain[i] = sys_en_sync;
			end else if (i == 0) begin : g_first
				assign en_chain[i] = sys_en_sync | pg_sync[i+1];
			end else if (i == NUM_RAILS - 1) begin : g_last
				assign en_chain[i] = sys_en_sync & rail_done[i-1];
			end else begin : g_mid
				assign en_chain[i] = (sys_en_sync & rail_done[i-1]) | pg_sync[i+1];
			end
		end
	endgenerate

	// A latched fault drops every rail at once
	assign en = en_chain & ~{NUM_RAILS{fault}};

	// Rails that are up and still waiting for their settle time
	assign settle_cand  = en & pg_sync & ~rail_done;
	// Lowest such rail owns the shared counter
	assign settle_sel   = settle_cand & (~settle_cand + 1'b1);
	assign delay_active = |settle_cand;

	always_ff @(posedge clk_in) begin
		if (reset) begin
			d_count   <= '0;
			rail_done <= '0;
		end else if (!sys_en_sync || fault) begin
			d_count   <= '0;
			rail_done <= '0;
		end else if (delay_active) begin
			if (d_count == DELAY_LIMIT) begin
				d_count   <= '0;
				rail_done <= rail_done | settle_sel;
			end else begin
				d_count <= d_count + 1'b1;
			end
		end else begin
			// Restart if the pending rail dropped before it settled
			d_count <= '0;
		end
	end

	assign sys_good = rail_done[NUM_RAILS-1];

	// Fault kills the enables now and the done flags on the next edge
	a_fault_off : assert property (@(posedge clk_in) disable iff (reset)
		fault |-> (en == '0) ##1 (rail_done == '0));

endmodule

//--- design/regs_pkg.sv
// Host register map package
// Address and data types, register addresses, fixed read values
// and the states of the req/ack register port

package regs_pkg;

	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Register addresses
	localparam reg_addr_t ADDR_VERSION = 8'd0;
	localparam reg_addr_t ADDR_CLEAR   = 8'd3;
	localparam reg_addr_t ADDR_PG_HIGH = 8'd5;
	localparam reg_addr_t ADDR_PG_LOW  = 8'd6;
	localparam reg_addr_t ADDR_STATUS  = 8'd7;

	// Version byte reported at ADDR_VERSION
	localparam reg_data_t FPGA_VERSION = 8'd6;

	// Read value of the error clear register
	localparam reg_data_t CLEAR_VALUE = 8'hff;

	// Four-phase port states
	typedef enum logic {
		REG_IDLE = 1'b0,
		REG_ACK  = 1'b1
	} reg_state_e;

endpackage

//--- design/seq_pkg.sv
// Power sequencer sizing package
// Default rail count, settle delay, watchdog length and timer width
// for the rail sequencer and the fault monitor

package seq_pkg;

	// Number of rails in the enable chain (at most 16)
	localparam int DEFAULT_NUM_RAILS = 15;

	// Settle time after a rail reports good
	localparam int DEFAULT_DELAY_CYCLES = 65536;

	// Longest allowed wait from enable to power-good
	localparam int DEFAULT_WATCHDOG_CYCLES = 8388608;

	// Shared width of the settle and watchdog counters
	localparam int COUNT_WIDTH = 24;

endpackage
